// File: rtl/sd_spi_pkg.sv
`default_nettype none

package sd_spi_pkg;

  // widths with a meaning on the card link and the log path
  typedef logic [5:0]  sd_cmd_index_t;
  typedef logic [31:0] sd_arg_t;
  typedef logic [7:0]  sd_r1_t;
  typedef logic [6:0]  crc7_t;
  typedef logic [8:0]  clk_div_t;
  typedef logic [7:0]  log_byte_t;
  typedef logic [4:0]  credit_t;

  // half periods in clk cycles, 400 kHz and 25 MHz from 100 MHz
  localparam clk_div_t CLK_DIV_SLOW = 9'd125;
  localparam clk_div_t CLK_DIV_FAST = 9'd2;

  // counted in card clocks
  localparam int POWER_UP_CLOCKS     = 80;
  localparam int RESP_TIMEOUT_CLOCKS = 64;

  // 115200 baud at 100 MHz
  localparam int UART_CLKS_PER_BIT = 868;

  localparam int CMD0_RETRIES   = 10;
  localparam int ACMD41_RETRIES = 20;

  // also the credit count after reset
  localparam int LOG_FIFO_DEPTH = 16;

  localparam sd_cmd_index_t CMD_GO_IDLE       = 6'd0;
  localparam sd_cmd_index_t CMD_SEND_IF_COND  = 6'd8;
  localparam sd_cmd_index_t CMD_READ_OCR      = 6'd58;
  localparam sd_cmd_index_t CMD_APP_CMD       = 6'd55;
  localparam sd_cmd_index_t ACMD_SEND_OP_COND = 6'd41;

  // 2.7-3.6 V range and check pattern AA
  localparam sd_arg_t ARG_IF_COND = 32'h0000_01AA;
  // host supports high capacity cards
  localparam sd_arg_t ARG_HCS     = 32'h4000_0000;

  localparam sd_r1_t R1_IDLE         = 8'h01;
  localparam sd_r1_t R1_READY        = 8'h00;
  localparam sd_r1_t R1_ILLEGAL_IDLE = 8'h05;

endpackage

`default_nettype wire

// File: rtl/sd_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module sd_clock_gen (
  input  logic clk,
  input  logic reset,
  input  logic fast,
  output logic sd_cclk,
  output logic rise,
  output logic fall
);
  import sd_spi_pkg::*;

  clk_div_t div_cnt;
  clk_div_t half_period;
  logic     toggle;

  assign toggle = (div_cnt == half_period - clk_div_t'(1));

  always_ff @(posedge clk) begin
    if (reset) begin
      div_cnt     <= '0;
      half_period <= CLK_DIV_SLOW;
      sd_cclk     <= 1'b0;
      rise        <= 1'b0;
      fall        <= 1'b0;
    end else begin
      // strobes line up with the cycle the line itself changes
      rise <= toggle && !sd_cclk;
      fall <= toggle && sd_cclk;
      if (toggle) begin
        div_cnt <= '0;
        sd_cclk <= ~sd_cclk;
        // new rate applies from the next half period on
        half_period <= fast ? CLK_DIV_FAST : CLK_DIV_SLOW;
      end else begin
        div_cnt <= div_cnt + clk_div_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/sd_cmd_tx.sv
`timescale 1ns/10ps
`default_nettype none

module sd_cmd_tx (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      rise,
  input  logic                      fall,
  input  logic                      cmd_start,
  input  sd_spi_pkg::sd_cmd_index_t cmd_index,
  input  sd_spi_pkg::sd_arg_t       cmd_arg,
  output logic                      sd_mosi,
  output logic                      cmd_done
);
  import sd_spi_pkg::*;

  logic [39:0] shift_q;
  crc7_t       crc_q;
  logic [5:0]  bit_cnt;
  logic        busy;
  logic        crc_fb;

  // x^7 + x^3 + 1, fed with the bit going out
  assign crc_fb = shift_q[39] ^ crc_q[6];

  // 48 falls done, card takes the end bit at this rise
  assign cmd_done = busy && rise && (bit_cnt == 6'd48);

  always_ff @(posedge clk) begin
    if (reset) begin
      busy    <= 1'b0;
      bit_cnt <= '0;
      sd_mosi <= 1'b1;
    end else if (cmd_start) begin
      busy    <= 1'b1;
      bit_cnt <= '0;
    end else if (cmd_done) begin
      busy <= 1'b0;
    end else if (busy && fall && (bit_cnt != 6'd48)) begin
      bit_cnt <= bit_cnt + 6'd1;
      if (bit_cnt < 6'd40) begin
        sd_mosi <= shift_q[39];
      end else if (bit_cnt < 6'd47) begin
        sd_mosi <= crc_q[6];
      end else begin
        // end bit, also the idle level
        sd_mosi <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_start) begin
      shift_q <= {2'b01, cmd_index, cmd_arg};
      crc_q   <= '0;
    end else if (busy && fall) begin
      if (bit_cnt < 6'd40) begin
        shift_q <= {shift_q[38:0], 1'b0};
        crc_q   <= {crc_q[5:3], crc_q[2] ^ crc_fb, crc_q[1:0], crc_fb};
      end else begin
        crc_q <= {crc_q[5:0], 1'b0};
      end
    end
  end

  // sequencer waits for cmd_done before the next frame
  assert property (@(posedge clk) disable iff (reset) cmd_start |-> !busy);

endmodule

`default_nettype wire

// File: rtl/sd_resp_rx.sv
`timescale 1ns/10ps
`default_nettype none

module sd_resp_rx (
  input  logic                clk,
  input  logic                reset,
  input  logic                rise,
  input  logic                sd_miso,
  input  logic                resp_start,
  input  logic                resp_long,
  output logic                resp_valid,
  output logic                resp_timeout,
  output sd_spi_pkg::sd_r1_t  resp_r1,
  output sd_spi_pkg::sd_arg_t resp_tail
);
  import sd_spi_pkg::*;

  logic [39:0] cap_q;
  logic [5:0]  wait_cnt;
  logic [5:0]  bit_cnt;
  logic [5:0]  bit_need;
  logic        waiting;
  logic        capturing;
  logic        long_q;

  // R1 alone or R1 followed by 32 bits for R3 and R7
  assign bit_need  = long_q ? 6'd40 : 6'd8;
  assign resp_r1   = long_q ? cap_q[39:32] : cap_q[7:0];
  assign resp_tail = long_q ? cap_q[31:0] : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      waiting      <= 1'b0;
      capturing    <= 1'b0;
      long_q       <= 1'b0;
      wait_cnt     <= '0;
      bit_cnt      <= '0;
      resp_valid   <= 1'b0;
      resp_timeout <= 1'b0;
    end else begin
      resp_valid   <= 1'b0;
      resp_timeout <= 1'b0;
      if (resp_start) begin
        waiting   <= 1'b1;
        capturing <= 1'b0;
        long_q    <= resp_long;
        wait_cnt  <= '0;
        bit_cnt   <= '0;
      end else if (rise && waiting) begin
        if (!sd_miso) begin
          // start bit is the MSB of R1
          waiting   <= 1'b0;
          capturing <= 1'b1;
          bit_cnt   <= 6'd1;
        end else if (wait_cnt == 6'(RESP_TIMEOUT_CLOCKS - 1)) begin
          waiting      <= 1'b0;
          resp_timeout <= 1'b1;
        end else begin
          wait_cnt <= wait_cnt + 6'd1;
        end
      end else if (rise && capturing) begin
        bit_cnt <= bit_cnt + 6'd1;
        if (bit_cnt == bit_need - 6'd1) begin
          capturing  <= 1'b0;
          resp_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rise && ((waiting && !sd_miso) || capturing)) begin
      cap_q <= {cap_q[38:0], sd_miso};
    end
  end

  // a new response starts only after the previous one has ended
  assert property (@(posedge clk) disable iff (reset) resp_start |-> !(waiting || capturing));

endmodule

`default_nettype wire

// File: rtl/sd_init_seq.sv
`timescale 1ns/10ps
`default_nettype none

module sd_init_seq (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      rise,
  input  logic                      cmd_done,
  input  logic                      resp_valid,
  input  logic                      resp_timeout,
  input  sd_spi_pkg::sd_r1_t        resp_r1,
  input  sd_spi_pkg::sd_arg_t       resp_tail,
  input  logic                      log_credit,
  output logic                      fast,
  output logic                      sd_cs,
  output logic                      cmd_start,
  output sd_spi_pkg::sd_cmd_index_t cmd_index,
  output sd_spi_pkg::sd_arg_t       cmd_arg,
  output logic                      resp_start,
  output logic                      resp_long,
  output logic                      log_valid,
  output sd_spi_pkg::log_byte_t     log_byte,
  output logic                      init_done,
  output logic                      init_error,
  output logic                      card_hc
);
  import sd_spi_pkg::*;

  typedef enum logic [3:0] {
    ST_POWER_UP,
    ST_SEND,
    ST_CMD_WAIT,
    ST_RESP_WAIT,
    ST_LOG_RESP,
    ST_LOG_TIMEOUT,
    ST_DECIDE,
    ST_DONE,
    ST_ERROR
  } state_t;

  state_t     state;
  logic [6:0] power_cnt;
  logic [4:0] retry_cnt;
  logic [1:0] log_idx;
  sd_r1_t     r1_q;
  sd_arg_t    tail_q;
  credit_t    credits;

  // upper case hex digit
  function automatic log_byte_t hex_char(input logic [3:0] nib);
    return (nib < 4'd10) ? (8'h30 + {4'h0, nib}) : (8'h37 + {4'h0, nib});
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= ST_POWER_UP;
      power_cnt  <= '0;
      retry_cnt  <= '0;
      log_idx    <= '0;
      sd_cs      <= 1'b1;
      fast       <= 1'b0;
      cmd_start  <= 1'b0;
      cmd_index  <= CMD_GO_IDLE;
      cmd_arg    <= '0;
      resp_start <= 1'b0;
      resp_long  <= 1'b0;
      log_valid  <= 1'b0;
      log_byte   <= '0;
      init_done  <= 1'b0;
      init_error <= 1'b0;
      card_hc    <= 1'b0;
    end else begin
      cmd_start  <= 1'b0;
      resp_start <= 1'b0;
      log_valid  <= 1'b0;
      case (state)
        ST_POWER_UP: begin
          // card wants its clocks with chip select high first
          if (rise) begin
            if (power_cnt == 7'(POWER_UP_CLOCKS - 1)) begin
              sd_cs <= 1'b0;
              state <= ST_SEND;
            end else begin
              power_cnt <= power_cnt + 7'd1;
            end
          end
        end
        ST_SEND: begin
          cmd_start <= 1'b1;
          state     <= ST_CMD_WAIT;
        end
        ST_CMD_WAIT: begin
          if (cmd_done) begin
            resp_start <= 1'b1;
            resp_long  <= (cmd_index == CMD_SEND_IF_COND) || (cmd_index == CMD_READ_OCR);
            state      <= ST_RESP_WAIT;
          end
        end
        ST_RESP_WAIT: begin
          if (resp_timeout) begin
            state <= ST_LOG_TIMEOUT;
          end else if (resp_valid) begin
            state <= ST_LOG_RESP;
          end
        end
        ST_LOG_RESP: begin
          // three bytes go out back to back once credits cover all of them
          if ((log_idx != 2'd0) || (credits >= credit_t'(3))) begin
            log_valid <= 1'b1;
            case (log_idx)
              2'd0:    log_byte <= "r";
              2'd1:    log_byte <= hex_char(r1_q[7:4]);
              default: log_byte <= hex_char(r1_q[3:0]);
            endcase
            if (log_idx == 2'd2) begin
              log_idx <= '0;
              state   <= ST_DECIDE;
            end else begin
              log_idx <= log_idx + 2'd1;
            end
          end
        end
        ST_LOG_TIMEOUT: begin
          if (credits != '0) begin
            log_valid <= 1'b1;
            log_byte  <= "e";
            state     <= ST_ERROR;
          end
        end
        ST_DECIDE: begin
          state <= ST_SEND;
          case (cmd_index)
            CMD_GO_IDLE: begin
              if (r1_q == R1_IDLE) begin
                retry_cnt <= '0;
                cmd_index <= CMD_SEND_IF_COND;
                cmd_arg   <= ARG_IF_COND;
              end else if (retry_cnt == 5'(CMD0_RETRIES - 1)) begin
                state <= ST_ERROR;
              end else begin
                retry_cnt <= retry_cnt + 5'd1;
              end
            end
            CMD_SEND_IF_COND: begin
              // older cards reject CMD8, newer ones echo voltage and pattern
              if ((r1_q == R1_ILLEGAL_IDLE) ||
                  ((r1_q == R1_IDLE) && (tail_q[11:0] == ARG_IF_COND[11:0]))) begin
                cmd_index <= CMD_READ_OCR;
                cmd_arg   <= '0;
              end else begin
                state <= ST_ERROR;
              end
            end
            CMD_READ_OCR: begin
              if (r1_q == R1_IDLE) begin
                // OCR bit 30 is CCS
                card_hc   <= tail_q[30];
                cmd_index <= CMD_APP_CMD;
                cmd_arg   <= '0;
              end else begin
                state <= ST_ERROR;
              end
            end
            CMD_APP_CMD: begin
              cmd_index <= ACMD_SEND_OP_COND;
              cmd_arg   <= ARG_HCS;
            end
            default: begin
              if (r1_q == R1_READY) begin
                state <= ST_DONE;
              end else if ((r1_q == R1_IDLE) && (retry_cnt != 5'(ACMD41_RETRIES - 1))) begin
                retry_cnt <= retry_cnt + 5'd1;
                cmd_index <= CMD_APP_CMD;
                cmd_arg   <= '0;
              end else begin
                state <= ST_ERROR;
              end
            end
          endcase
        end
        ST_DONE: begin
          init_done <= 1'b1;
          fast      <= 1'b1;
        end
        default: begin
          init_error <= 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == ST_RESP_WAIT) && resp_valid) begin
      r1_q   <= resp_r1;
      tail_q <= resp_tail;
    end
  end

  // one credit per byte sent, one back per byte the UART takes
  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= credit_t'(LOG_FIFO_DEPTH);
    end else if (log_credit && !log_valid) begin
      credits <= credits + credit_t'(1);
    end else if (!log_credit && log_valid) begin
      credits <= credits - credit_t'(1);
    end
  end

  assert property (@(posedge clk) disable iff (reset) credits <= credit_t'(LOG_FIFO_DEPTH));

endmodule

`default_nettype wire

// File: rtl/uart_log_tx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_log_tx (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  log_valid,
  input  sd_spi_pkg::log_byte_t log_byte,
  output logic                  log_credit,
  output logic                  uart_tx
);
  import sd_spi_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_START,
    S_DATA,
    S_STOP
  } tx_state_t;

  log_byte_t  fifo_mem [LOG_FIFO_DEPTH];
  logic [3:0] wr_ptr;
  logic [3:0] rd_ptr;
  logic [4:0] fill;
  tx_state_t  tx_state;
  log_byte_t  tx_byte;
  logic [9:0] baud_cnt;
  logic [2:0] bit_idx;
  logic       period_end;
  logic       pop;

  assign period_end = (baud_cnt == 10'(UART_CLKS_PER_BIT - 1));
  // next byte follows the stop bit without a gap
  assign pop = (fill != '0) && ((tx_state == S_IDLE) || ((tx_state == S_STOP) && period_end));

  always_ff @(posedge clk) begin
    if (log_valid) begin
      fifo_mem[wr_ptr] <= log_byte;
    end
    if (pop) begin
      tx_byte <= fifo_mem[rd_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill       <= '0;
      tx_state   <= S_IDLE;
      baud_cnt   <= '0;
      bit_idx    <= '0;
      uart_tx    <= 1'b1;
      log_credit <= 1'b0;
    end else begin
      log_credit <= pop;
      if (log_valid) begin
        wr_ptr <= wr_ptr + 4'd1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 4'd1;
      end
      case ({log_valid, pop})
        2'b10:   fill <= fill + 5'd1;
        2'b01:   fill <= fill - 5'd1;
        default: fill <= fill;
      endcase
      if ((tx_state == S_IDLE) || period_end) begin
        baud_cnt <= '0;
      end else begin
        baud_cnt <= baud_cnt + 10'd1;
      end
      if (pop) begin
        tx_state <= S_START;
        uart_tx  <= 1'b0;
      end else if (period_end) begin
        case (tx_state)
          S_START: begin
            tx_state <= S_DATA;
            bit_idx  <= '0;
            uart_tx  <= tx_byte[0];
          end
          S_DATA: begin
            // LSB first
            if (bit_idx == 3'd7) begin
              tx_state <= S_STOP;
              uart_tx  <= 1'b1;
            end else begin
              bit_idx <= bit_idx + 3'd1;
              uart_tx <= tx_byte[bit_idx + 3'd1];
            end
          end
          default: begin
            tx_state <= S_IDLE;
          end
        endcase
      end
    end
  end

  // credits on the sender side keep the FIFO from overflowing
  assert property (@(posedge clk) disable iff (reset) log_valid |-> (fill != 5'(LOG_FIFO_DEPTH)));

endmodule

`default_nettype wire

// File: rtl/sd_spi_init_top.sv
`timescale 1ns/10ps
`default_nettype none

module sd_spi_init_top (
  input  logic clk,
  input  logic reset,
  input  logic sd_miso,
  output logic sd_cclk,
  output logic sd_mosi,
  output logic sd_cs,
  output logic uart_tx,
  output logic init_done,
  output logic init_error,
  output logic card_hc
);
  import sd_spi_pkg::*;

  logic          rise;
  logic          fall;
  logic          fast;
  logic          cmd_start;
  sd_cmd_index_t cmd_index;
  sd_arg_t       cmd_arg;
  logic          cmd_done;
  logic          resp_start;
  logic          resp_long;
  logic          resp_valid;
  logic          resp_timeout;
  sd_r1_t        resp_r1;
  sd_arg_t       resp_tail;
  logic          log_valid;
  log_byte_t     log_byte;
  logic          log_credit;

  // all port names match the wires above
  sd_clock_gen sd_clock_gen_i (.*);

  sd_cmd_tx sd_cmd_tx_i (.*);

  sd_resp_rx sd_resp_rx_i (.*);

  sd_init_seq sd_init_seq_i (.*);

  uart_log_tx uart_log_tx_i (.*);

endmodule

`default_nettype wire

// File: test/sd_card_model.sv
`timescale 1ns/10ps
`default_nettype none

module sd_card_model (
  input  logic                  sd_cclk,
  input  logic                  sd_cs,
  input  logic                  sd_mosi,
  output logic                  sd_miso,
  input  logic [7:0]            idle_acmd41,
  input  logic                  ocr_ccs,
  input  logic                  silent,
  output logic [47:0]           frame_bits,
  output logic                  frame_strobe
);
  import sd_spi_pkg::*;

  logic [47:0] shift;
  logic [39:0] reply;
  int          bit_cnt;
  int          acmd41_seen;
  int          reply_gap;
  int          reply_left;
  logic        in_frame;

  initial begin
    sd_miso      = 1'b1;
    frame_bits   = '0;
    frame_strobe = 1'b0;
    shift        = '0;
    reply        = '0;
    bit_cnt      = 0;
    acmd41_seen  = 0;
    reply_gap    = 0;
    reply_left   = 0;
    in_frame     = 1'b0;
  end

  // answer for one decoded frame, R1 left aligned
  task automatic prepare_reply(input sd_cmd_index_t idx, input sd_arg_t arg);
    reply_left = 8;
    case (idx)
      CMD_GO_IDLE: reply = {R1_IDLE, 32'h0};
      CMD_SEND_IF_COND: begin
        // echo of voltage code and pattern
        reply      = {R1_IDLE, arg};
        reply_left = 40;
      end
      CMD_READ_OCR: begin
        reply      = {R1_IDLE, 1'b1, ocr_ccs, 30'h00FF_8000};
        reply_left = 40;
      end
      CMD_APP_CMD: reply = {R1_IDLE, 32'h0};
      ACMD_SEND_OP_COND: begin
        reply       = {(acmd41_seen < int'(idle_acmd41)) ? R1_IDLE : R1_READY, 32'h0};
        acmd41_seen = acmd41_seen + 1;
      end
      default: reply = {8'h04, 32'h0};
    endcase
    reply_gap = 2;
    if (silent) begin
      reply_left = 0;
    end
  endtask

  always @(posedge sd_cclk) begin
    if (sd_cs) begin
      // deselected card forgets everything
      in_frame    = 1'b0;
      bit_cnt     = 0;
      acmd41_seen = 0;
    end else if (!in_frame && (sd_mosi === 1'b0)) begin
      in_frame = 1'b1;
      shift    = '0;
      bit_cnt  = 1;
    end else if (in_frame) begin
      shift   = {shift[46:0], sd_mosi};
      bit_cnt = bit_cnt + 1;
      if (bit_cnt == 48) begin
        in_frame   = 1'b0;
        frame_bits = shift;
        frame_strobe <= ~frame_strobe;
        prepare_reply(shift[45:40], shift[39:8]);
      end
    end
  end

  // miso changes shortly after the card clock falls
  always @(negedge sd_cclk) begin
    #2;
    if (reply_gap != 0) begin
      reply_gap = reply_gap - 1;
      sd_miso <= 1'b1;
    end else if (reply_left != 0) begin
      sd_miso <= reply[39];
      reply      = {reply[38:0], 1'b1};
      reply_left = reply_left - 1;
    end else begin
      sd_miso <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: test/tb_sd_spi_init.sv
`timescale 1ns/10ps
`default_nettype none

module tb_sd_spi_init;
  import sd_spi_pkg::*;

  localparam int CHAR_CLKS    = 10 * UART_CLKS_PER_BIT;
  localparam int INIT_TIMEOUT = 3_000_000;

  logic        clk;
  logic        reset;
  logic        sd_miso;
  logic        sd_cclk;
  logic        sd_mosi;
  logic        sd_cs;
  logic        uart_tx;
  logic        init_done;
  logic        init_error;
  logic        card_hc;
  logic [7:0]  idle_acmd41;
  logic        ocr_ccs;
  logic        silent;
  logic [47:0] frame_bits;
  logic        frame_strobe;

  logic [47:0] frames[$];
  byte         uart_chars[$];
  logic [31:0] lfsr_state;
  int          errors;
  int          test_errors;
  int          tests_run;
  int          tests_failed;

  sd_spi_init_top sd_spi_init_top_i (.*);

  sd_card_model card (.*);

  always #20 clk = ~clk;

  // galois form with taps for x^32 + x^31 + x^29 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      value      = (value << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // reference CRC7 by long division one bit at a time
  function automatic crc7_t crc7_of(input logic [39:0] data);
    crc7_t crc;
    logic  fb;
    crc = '0;
    for (int i = 39; i >= 0; i--) begin
      fb  = data[i] ^ crc[6];
      crc = {crc[5:0], 1'b0};
      if (fb) begin
        crc = crc ^ 7'h09;
      end
    end
    return crc;
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
    assert (got === exp) else begin
      $display("[ERROR] %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("failure at %0t ns: %s", $time, what);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors != test_errors) begin
      tests_failed++;
      $display("%s: fail", name);
    end else begin
      $display("%s: pass", name);
    end
    test_errors = errors;
  endtask

  // uart decoder samples at the falling clk edge
  always begin
    byte ch;
    @(negedge uart_tx);
    repeat (UART_CLKS_PER_BIT / 2) @(negedge clk);
    if (uart_tx == 1'b0) begin
      for (int i = 0; i < 8; i++) begin
        repeat (UART_CLKS_PER_BIT) @(negedge clk);
        ch[i] = uart_tx;
      end
      repeat (UART_CLKS_PER_BIT) @(negedge clk);
      check_value("uart_tx stop bit", 1, uart_tx);
      uart_chars.push_back(ch);
    end
  end

  always @(frame_strobe) begin
    frames.push_back(frame_bits);
  end

  task automatic apply_reset;
    @(posedge clk);
    #2 reset = 1'b1;
    repeat (2) @(posedge clk);
    #2 reset = 1'b0;
    @(negedge clk);
    frames.delete();
    uart_chars.delete();
  endtask

  task automatic wait_init_end;
    int n;
    n = 0;
    while (!init_done && !init_error && n < INIT_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    check_true(n < INIT_TIMEOUT, "timeout waiting for init_done or init_error");
  endtask

  task automatic wait_uart_chars(input int count);
    int n;
    n = 0;
    while (uart_chars.size() < count && n < (count + 2) * CHAR_CLKS) begin
      @(negedge clk);
      n++;
    end
    check_true(uart_chars.size() >= count, "timeout waiting for UART characters");
    // a stray extra character would show up here
    repeat (2 * CHAR_CLKS) @(negedge clk);
  endtask

  task automatic wait_cclk_change(output int cycles);
    logic start;
    start  = sd_cclk;
    cycles = 0;
    while (sd_cclk === start && cycles < 1000) begin
      @(negedge clk);
      cycles++;
    end
    check_true(cycles < 1000, "sd_cclk stopped toggling");
  endtask

  task automatic check_uart_text(input string exp_text);
    check_value("uart char count", exp_text.len(), uart_chars.size());
    for (int i = 0; i < exp_text.len() && i < uart_chars.size(); i++) begin
      check_value($sformatf("uart_text[%0d]", i), exp_text[i], uart_chars[i]);
    end
  endtask

  task automatic run_normal_card;
    int            k;
    int            ccs;
    int            rises;
    int            n;
    int            half;
    logic          prev;
    string         exp_text;
    sd_cmd_index_t exp_idx[$];
    take_bits(2, k);
    k = k + 1;
    take_bits(1, ccs);
    idle_acmd41 = 8'(k);
    ocr_ccs     = ccs[0];
    silent      = 1'b0;
    apply_reset();
    check_value("sd_cs", 1, sd_cs);
    check_value("sd_mosi", 1, sd_mosi);
    check_value("init_done", 0, init_done);
    check_value("init_error", 0, init_error);
    finish_test("reset state");

    rises = 0;
    n     = 0;
    prev  = sd_cclk;
    while (sd_cs && n < INIT_TIMEOUT) begin
      @(negedge clk);
      if (sd_cclk && !prev) begin
        rises++;
      end
      prev = sd_cclk;
      n++;
    end
    check_true(n < INIT_TIMEOUT, "timeout waiting for sd_cs to go low");
    check_true(rises >= POWER_UP_CLOCKS, "too few card clocks before chip select");
    finish_test("power-up clocks");

    wait_init_end();
    check_value("init_done", 1, init_done);
    check_value("init_error", 0, init_error);
    exp_idx = '{CMD_GO_IDLE, CMD_SEND_IF_COND, CMD_READ_OCR};
    exp_text = "r01r01r01";
    for (int i = 0; i <= k; i++) begin
      exp_idx.push_back(CMD_APP_CMD);
      exp_idx.push_back(ACMD_SEND_OP_COND);
      // CMD55 answer first, ACMD41 is ready only on the last pair
      if (i < k) begin
        exp_text = {exp_text, "r01r01"};
      end else begin
        exp_text = {exp_text, "r01r00"};
      end
    end
    check_value("frame count", exp_idx.size(), frames.size());
    for (int i = 0; i < frames.size() && i < exp_idx.size(); i++) begin
      check_value("frame start bits", 2'b01, frames[i][47:46]);
      check_value("cmd_index", exp_idx[i], frames[i][45:40]);
      check_value("frame crc7", crc7_of(frames[i][47:8]), frames[i][7:1]);
      check_value("frame end bit", 1, frames[i][0]);
    end
    finish_test($sformatf("command frames, %0d idle ACMD41", k));

    check_value("card_hc", ccs[0], card_hc);
    // fast rate applies after a toggle or two
    repeat (3) wait_cclk_change(half);
    wait_cclk_change(half);
    check_value("sd_cclk half period", CLK_DIV_FAST, half);
    finish_test("init done, capacity and fast clock");

    wait_uart_chars(exp_text.len());
    check_uart_text(exp_text);
    finish_test("uart log, normal card");
  endtask

  task automatic run_silent_card;
    silent = 1'b1;
    apply_reset();
    wait_init_end();
    check_value("init_error", 1, init_error);
    check_value("init_done", 0, init_done);
    wait_uart_chars(1);
    check_uart_text("e");
    finish_test("silent card");
  endtask

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    idle_acmd41  = 8'd1;
    ocr_ccs      = 1'b0;
    silent       = 1'b0;
    lfsr_state   = 32'd75161;
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    run_normal_card();
    run_silent_card();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
rtl/sd_spi_pkg.sv
rtl/sd_clock_gen.sv
rtl/sd_cmd_tx.sv
rtl/sd_resp_rx.sv
rtl/sd_init_seq.sv
rtl/uart_log_tx.sv
rtl/sd_spi_init_top.sv
test/sd_card_model.sv
test/tb_sd_spi_init.sv

// File: Bender.yml
package:
  name: sd_spi_init

sources:
  - rtl/sd_spi_pkg.sv
  - rtl/sd_clock_gen.sv
  - rtl/sd_cmd_tx.sv
  - rtl/sd_resp_rx.sv
  - rtl/sd_init_seq.sv
  - rtl/uart_log_tx.sv
  - rtl/sd_spi_init_top.sv
  - target: test
    files:
      - test/sd_card_model.sv
      - test/tb_sd_spi_init.sv
